// File: nlc_num_pkg.sv
// Signed Q16.16 arithmetic that wraps on overflow; ADC readings enter as raw unsigned words
package nlc_num_pkg;

	// Fixed-point word format
	localparam int FRAC_BITS = 16;
	localparam int WORD_W = 32;

	// ADC reading and corrected output width
	localparam int SAMPLE_W = 21;

	// Correction polynomial order
	localparam int ORDER = 5;

	typedef logic signed [WORD_W-1:0] word_t;
	typedef logic [SAMPLE_W-1:0] sample_t;

	// Calibration for one channel
	// Constant term sits in coeff[0]
	typedef struct packed {
		word_t neg_mean;
		word_t recip_stdev;
		word_t [ORDER:0] coeff;
	} coeff_set_t;

	// Full 64-bit product, arithmetic shift back to Q16.16 and wrap to one word
	function automatic word_t q_mul(input word_t a, input word_t b);
		logic signed [2*WORD_W-1:0] prod;
		prod = a * b;
		return word_t'(prod >>> FRAC_BITS);
	endfunction

	// Integer part of a word, low SAMPLE_W bits only
	function automatic sample_t q_to_sample(input word_t w);
		word_t whole;
		whole = w >>> FRAC_BITS;
		return whole[SAMPLE_W-1:0];
	endfunction

endpackage

// File: nlc_ctrl_pkg.sv
// Result writes carry a 10-bit channel field, so at most 1024 channels can be addressed
package nlc_ctrl_pkg;
	import nlc_num_pkg::*;

	// Refit and error modes are not built and run on the stored set
	typedef enum logic [1:0] {
		MODE_LOAD = 2'b00,
		MODE_REFIT = 2'b01,
		MODE_ERROR = 2'b10,
		MODE_STORED = 2'b11
	} mode_e;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RUN,
		ST_PUBLISH
	} state_e;

	// Step 0 normalizes, steps 1 to ORDER run Horner
	typedef logic [$clog2(ORDER+1)-1:0] step_t;

	localparam int CHAN_W = 10;
	typedef logic [CHAN_W-1:0] chan_t;

	typedef struct packed {
		logic valid;
		chan_t chan;
		sample_t value;
	} result_wr_t;

endpackage

// File: coeff_bank.sv
// Loads every channel's set only on a MODE_LOAD capture; all other modes keep the stored sets
`timescale 1ns/1ns

module coeff_bank
	import nlc_num_pkg::*, nlc_ctrl_pkg::*;
#(
	parameter int CH_COUNT = 16,
	localparam int IDX_W = $clog2(CH_COUNT)
) (
	input logic clk,
	input logic reset,

	// Capture strobe and mode sampled with it
	input logic capture_i,
	input mode_e mode_i,
	input coeff_set_t [CH_COUNT-1:0] coeff_i,

	// Combinational read port for the engine
	input logic [IDX_W-1:0] chan_i,
	output coeff_set_t coeff_o
);

	coeff_set_t [CH_COUNT-1:0] bank_q;
	logic load;

	// Refit and error codes fall through to keeping the set
	always_comb begin
		case (mode_i)
			MODE_LOAD: load = capture_i;
			default: load = 1'b0;
		endcase
	end

	// Cleared so a stored-mode run straight after reset gives zeros
	always_ff @(posedge clk) begin
		if (reset) begin
			bank_q <= '0;
		end else if (load) begin
			bank_q <= coeff_i;
		end
	end

	assign coeff_o = bank_q[chan_i];

endmodule

// File: channel_buffer.sv
// Published outputs change only on publish, so a run in progress never shows on x_lin_o
`timescale 1ns/1ns

module channel_buffer
	import nlc_num_pkg::*, nlc_ctrl_pkg::*;
#(
	parameter int CH_COUNT = 16,
	localparam int IDX_W = $clog2(CH_COUNT)
) (
	input logic clk,
	input logic reset,

	// Reading capture
	input logic capture_i,
	input sample_t [CH_COUNT-1:0] x_adc_i,

	// Reading served to the engine
	input logic [IDX_W-1:0] chan_i,
	output sample_t sample_o,

	// Result collection and publish
	input result_wr_t result_i,
	input logic publish_i,
	output sample_t [CH_COUNT-1:0] x_lin_o
);

	sample_t [CH_COUNT-1:0] adc_q;
	sample_t [CH_COUNT-1:0] result_q;

	// All channels captured in the same cycle
	always_ff @(posedge clk) begin
		if (capture_i) begin
			adc_q <= x_adc_i;
		end
	end

	// One channel finishes at a time
	always_ff @(posedge clk) begin
		if (result_i.valid) begin
			result_q[result_i.chan] <= result_i.value;
		end
	end

	assign sample_o = adc_q[chan_i];

	// Every channel moves to the outputs together
	always_ff @(posedge clk) begin
		if (reset) begin
			x_lin_o <= '0;
		end else if (publish_i) begin
			x_lin_o <= result_q;
		end
	end

endmodule

// File: poly_engine.sv
// One multiply-add per cycle, ORDER+1 cycles per channel; strobes while busy are dropped
`timescale 1ns/1ns

module poly_engine
	import nlc_num_pkg::*, nlc_ctrl_pkg::*;
#(
	parameter int CH_COUNT = 16,
	localparam int IDX_W = $clog2(CH_COUNT)
) (
	input logic clk,
	input logic reset,

	// Start strobe and capture pulse to the stores
	input logic srdyi_i,
	output logic capture_o,

	// Channel select and the data it returns
	output logic [IDX_W-1:0] chan_o,
	input sample_t sample_i,
	input coeff_set_t coeff_i,

	// Result write and publish
	output result_wr_t result_o,
	output logic publish_o,
	output logic srdyo_o
);

	state_e state_q;
	logic [IDX_W-1:0] chan_q;
	step_t step_q;
	logic srdyo_q;

	// Datapath registers
	word_t norm_q;
	word_t acc_q;

	logic run;
	logic last_step;
	word_t reading;
	word_t mul_a;
	word_t mul_b;
	word_t prod;
	word_t acc_next;

	assign run = (state_q == ST_RUN);
	assign last_step = (step_q == step_t'(ORDER));

	// Readings go in as raw unsigned words
	assign reading = word_t'({{(WORD_W-SAMPLE_W){1'b0}}, sample_i});

	// Shared multiplier
	// Step 0 feeds it the offset reading and the reciprocal deviation
	always_comb begin
		if (step_q == '0) begin
			mul_a = reading + coeff_i.neg_mean;
			mul_b = coeff_i.recip_stdev;
		end else begin
			mul_a = acc_q;
			mul_b = norm_q;
		end
		prod = q_mul(mul_a, mul_b);
		acc_next = prod + coeff_i.coeff[ORDER - step_q];
	end

	// Sequencer
	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= ST_IDLE;
			chan_q <= '0;
			step_q <= '0;
			srdyo_q <= 1'b0;
		end else begin
			srdyo_q <= publish_o;
			case (state_q)
				ST_IDLE: begin
					if (srdyi_i) begin
						state_q <= ST_RUN;
						chan_q <= '0;
						step_q <= '0;
					end
				end
				ST_RUN: begin
					if (last_step) begin
						step_q <= '0;
						if (chan_q == IDX_W'(CH_COUNT - 1)) begin
							state_q <= ST_PUBLISH;
						end else begin
							chan_q <= chan_q + 1'b1;
						end
					end else begin
						step_q <= step_q + 1'b1;
					end
				end
				ST_PUBLISH: begin
					state_q <= ST_IDLE;
				end
				default: begin
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

	// Normalize, then seed Horner with the top coefficient
	always_ff @(posedge clk) begin
		if (run) begin
			if (step_q == '0) begin
				norm_q <= prod;
				acc_q <= coeff_i.coeff[ORDER];
			end else begin
				acc_q <= acc_next;
			end
		end
	end

	assign capture_o = srdyi_i && (state_q == ST_IDLE);
	assign chan_o = chan_q;

	// Last Horner sum goes straight to the buffer
	always_comb begin
		result_o.valid = run && last_step;
		result_o.chan = chan_t'(chan_q);
		result_o.value = q_to_sample(acc_next);
	end

	assign publish_o = (state_q == ST_PUBLISH);

	// Rises on the same edge that loads x_lin_o
	assign srdyo_o = srdyo_q;

endmodule

// File: nlc_top.sv
// CH_COUNT must be between 2 and 1024; srdyo_o follows an accepted srdyi_i by CH_COUNT*(ORDER+1)+1 cycles
`timescale 1ns/1ns

module nlc_top
	import nlc_num_pkg::*, nlc_ctrl_pkg::*;
#(
	parameter int CH_COUNT = 16,
	localparam int IDX_W = $clog2(CH_COUNT)
) (
	input logic clk,
	input logic reset,
	input logic srdyi_i,
	input mode_e mode_i,
	input sample_t [CH_COUNT-1:0] x_adc_i,
	input coeff_set_t [CH_COUNT-1:0] coeff_i,
	output logic srdyo_o,
	output sample_t [CH_COUNT-1:0] x_lin_o
);

	logic capture;
	logic [IDX_W-1:0] chan;
	sample_t sample;
	coeff_set_t coeff_set;
	result_wr_t result_wr;
	logic publish;

	coeff_bank #(
		.CH_COUNT(CH_COUNT)
	) u_coeff_bank (
		.clk(clk),
		.reset(reset),
		.capture_i(capture),
		.mode_i(mode_i),
		.coeff_i(coeff_i),
		.chan_i(chan),
		.coeff_o(coeff_set)
	);

	channel_buffer #(
		.CH_COUNT(CH_COUNT)
	) u_channel_buffer (
		.clk(clk),
		.reset(reset),
		.capture_i(capture),
		.x_adc_i(x_adc_i),
		.chan_i(chan),
		.sample_o(sample),
		.result_i(result_wr),
		.publish_i(publish),
		.x_lin_o(x_lin_o)
	);

	poly_engine #(
		.CH_COUNT(CH_COUNT)
	) u_poly_engine (
		.clk(clk),
		.reset(reset),
		.srdyi_i(srdyi_i),
		.capture_o(capture),
		.chan_o(chan),
		.sample_i(sample),
		.coeff_i(coeff_set),
		.result_o(result_wr),
		.publish_o(publish),
		.srdyo_o(srdyo_o)
	);

endmodule

// File: nlc_asserts.sv
// Latency here counts one publish cycle after the last channel step
`timescale 1ns/1ns

module nlc_asserts
	import nlc_num_pkg::*;
#(
	parameter int CH_COUNT = 16,
	localparam int LAT = CH_COUNT * (ORDER + 1) + 1
) (
	input logic clk,
	input logic reset,
	input logic capture_i,
	input logic srdyo_i
);

	int fail_cnt = 0;

	done_one_cycle: assert property (@(posedge clk) disable iff (reset)
		srdyo_i |=> !srdyo_i)
	else begin
		$error("srdyo_o stayed high for more than one cycle");
		fail_cnt++;
	end

	// Registered done is first seen one sample after the edge that sets it
	done_after_capture: assert property (@(posedge clk) disable iff (reset)
		capture_i |-> ##(LAT + 1) srdyo_i)
	else begin
		$error("srdyo_o did not follow capture after %0d cycles", LAT);
		fail_cnt++;
	end

	// Every done pulse traces back to a capture
	done_has_capture: assert property (@(posedge clk) disable iff (reset)
		$rose(srdyo_i) |-> $past(capture_i, LAT + 1))
	else begin
		$error("srdyo_o rose without a capture %0d cycles before", LAT);
		fail_cnt++;
	end

	// Engine stays busy up to the publish edge
	no_capture_in_run: assert property (@(posedge clk) disable iff (reset)
		capture_i |=> (!capture_i) [*LAT])
	else begin
		$error("capture pulsed while the engine was running");
		fail_cnt++;
	end

endmodule

bind poly_engine nlc_asserts #(
	.CH_COUNT(CH_COUNT)
) u_asserts (
	.clk(clk),
	.reset(reset),
	.capture_i(capture_o),
	.srdyo_i(srdyo_o)
);

// File: nlc_checker.sv
// Assumes a start is taken only while idle and done follows after CH_COUNT*(ORDER+1)+1 cycles
`timescale 1ns/1ns

module nlc_checker
	import nlc_num_pkg::*, nlc_ctrl_pkg::*;
#(
	parameter int CH_COUNT = 4,
	localparam int LAT = CH_COUNT * (ORDER + 1) + 1
) (
	input logic clk,
	input logic reset,
	input logic srdyi_i,
	input mode_e mode_i,
	input logic srdyo_i,
	input sample_t [CH_COUNT-1:0] x_lin_i,
	input sample_t [CH_COUNT-1:0] exp_i,
	output int err_cnt_o,
	output int run_cnt_o
);

	int cyc;
	int done_cyc;
	logic busy;
	mode_e run_mode;
	sample_t [CH_COUNT-1:0] exp_q;
	sample_t [CH_COUNT-1:0] held_q;

	// Mid-cycle, clear of the clock edge and of the input drive
	always @(negedge clk) begin : watch
		int c;
		logic bad;
		if (reset !== 1'b0) begin
			cyc = 0;
			busy = 1'b0;
			held_q = '0;
			err_cnt_o = 0;
			run_cnt_o = 0;
		end else begin
			cyc++;
			if (busy && cyc == done_cyc) begin
				bad = 1'b0;
				if (srdyo_i !== 1'b1) begin
					$display("srdyo_o did not rise %0d cycles after the accepted start", LAT);
					err_cnt_o++;
					bad = 1'b1;
				end
				for (c = 0; c < CH_COUNT; c++) begin
					if (x_lin_i[c] !== exp_q[c]) begin
						$display("ERR %0t: run %0d ch %0d expected %06h actual %06h",
							$time, run_cnt_o, c, exp_q[c], x_lin_i[c]);
						err_cnt_o++;
						bad = 1'b1;
					end
				end
				$display("run %0d %s at %0t: %s", run_cnt_o, run_mode.name(), $time,
					bad ? "mismatch" : "ok");
				run_cnt_o++;
				held_q = x_lin_i;
				busy = 1'b0;
			end else begin
				if (srdyo_i !== 1'b0) begin
					$display("extra srdyo_o pulse at %0t with no run due to finish", $time);
					err_cnt_o++;
				end
				for (c = 0; c < CH_COUNT; c++) begin
					if (x_lin_i[c] !== held_q[c]) begin
						$display("ERR %0t: ch %0d x_lin_o changed between publishes, %06h to %06h",
							$time, c, held_q[c], x_lin_i[c]);
						err_cnt_o++;
					end
				end
				held_q = x_lin_i;
			end
			// Idle engine takes the strobe on the coming edge
			if (!busy && srdyi_i) begin
				busy = 1'b1;
				done_cyc = cyc + 1 + LAT;
				exp_q = exp_i;
				run_mode = mode_i;
			end
		end
	end

endmodule

// File: tb_nlc.sv
// Four channels only; random readings come from an LFSR with a fixed seed, so every run is repeatable
`timescale 1ns/1ns

module tb_nlc
	import nlc_num_pkg::*, nlc_ctrl_pkg::*;
();

	localparam int CH = 4;
	localparam int LAT = CH * (ORDER + 1) + 1;
	localparam int ROWS = 8;
	localparam int LIMIT = ROWS * (LAT + 4) + 20;
	localparam int ONE = 1 << FRAC_BITS;

	// One stimulus row and the words the model expects from it
	typedef struct packed {
		mode_e mode;
		logic busy;
		logic [1:0] gap;
		sample_t [CH-1:0] adc;
		coeff_set_t [CH-1:0] coeff;
		sample_t [CH-1:0] exp_w;
	} row_t;

	logic clk;
	logic reset;
	logic srdyi;
	mode_e mode;
	sample_t [CH-1:0] x_adc;
	coeff_set_t [CH-1:0] coeff;
	logic srdyo;
	sample_t [CH-1:0] x_lin;
	sample_t [CH-1:0] exp_words;
	int err_cnt;
	int run_cnt;
	int cycles = 0;
	logic [31:0] lfsr_state;
	row_t rows [ROWS];

	nlc_top #(
		.CH_COUNT(CH)
	) u_dut (
		.clk(clk),
		.reset(reset),
		.srdyi_i(srdyi),
		.mode_i(mode),
		.x_adc_i(x_adc),
		.coeff_i(coeff),
		.srdyo_o(srdyo),
		.x_lin_o(x_lin)
	);

	nlc_checker #(
		.CH_COUNT(CH)
	) u_checker (
		.clk(clk),
		.reset(reset),
		.srdyi_i(srdyi),
		.mode_i(mode),
		.srdyo_i(srdyo),
		.x_lin_i(x_lin),
		.exp_i(exp_words),
		.err_cnt_o(err_cnt),
		.run_cnt_o(run_cnt)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic int scaled_product(input int a, input int b);
		longint p;
		p = longint'(a) * longint'(b);
		return int'(p >>> FRAC_BITS);
	endfunction

	// Normalize, then Horner from the top coefficient down
	function automatic sample_t correct_reading(input sample_t x, input coeff_set_t cs);
		int xi;
		int norm;
		int acc;
		int k;
		xi = x;
		norm = scaled_product(xi + cs.neg_mean, cs.recip_stdev);
		acc = cs.coeff[ORDER];
		for (k = ORDER - 1; k >= 0; k--) begin
			acc = scaled_product(acc, norm) + cs.coeff[k];
		end
		return sample_t'(acc >>> FRAC_BITS);
	endfunction

	function automatic coeff_set_t cal_set(input int ch, input int variant);
		coeff_set_t cs;
		if (variant == 0) begin
			cs.neg_mean = word_t'(-(16 + ch) * ONE);
			cs.recip_stdev = word_t'(ONE / 8 + ch * 1024);
			cs.coeff = {word_t'(-ONE / 8), word_t'(ONE / 4), word_t'(-3 * ONE / 2),
				word_t'(3 * ONE), word_t'(50 * ONE), word_t'((1000 + 100 * ch) * ONE)};
		end else begin
			cs.neg_mean = word_t'(-(8 + ch) * ONE);
			cs.recip_stdev = word_t'(ONE / 4);
			cs.coeff = {word_t'(ONE / 16), word_t'(-ONE), word_t'(ONE / 2),
				word_t'(3 * ONE / 2), word_t'(-20 * ONE), word_t'((5000 - 200 * ch) * ONE)};
		end
		return cs;
	endfunction

	// Variant 2 puts junk on the ports; adc_kind 0 random, 1 ramp, 2 full scale
	task automatic fill_row(input int r, input mode_e m, input logic busy,
		input logic [1:0] gap, input int variant, input int adc_kind);
		int c;
		int k;
		rows[r].mode = m;
		rows[r].busy = busy;
		rows[r].gap = gap;
		for (c = 0; c < CH; c++) begin
			case (adc_kind)
				0: rows[r].adc[c] = sample_t'(random_bits(SAMPLE_W));
				1: rows[r].adc[c] = sample_t'(32'h0F_0000 + c * 32'h0_9876);
				default: rows[r].adc[c] = '1;
			endcase
			if (variant < 2) begin
				rows[r].coeff[c] = cal_set(c, variant);
			end else begin
				rows[r].coeff[c].neg_mean = random_bits(WORD_W);
				rows[r].coeff[c].recip_stdev = random_bits(WORD_W);
				for (k = 0; k <= ORDER; k++) begin
					rows[r].coeff[c].coeff[k] = random_bits(WORD_W);
				end
			end
		end
	endtask

	task automatic build_table();
		coeff_set_t [CH-1:0] stored;
		int r;
		int c;
		lfsr_state = 32'd81586;
		fill_row(0, MODE_STORED, 1'b0, 2'd1, 2, 0);
		fill_row(1, MODE_LOAD, 1'b0, 2'd2, 0, 1);
		fill_row(2, MODE_STORED, 1'b0, 2'd0, 2, 0);
		fill_row(3, MODE_REFIT, 1'b0, 2'd1, 2, 0);
		fill_row(4, MODE_ERROR, 1'b0, 2'd0, 2, 0);
		fill_row(5, MODE_LOAD, 1'b1, 2'd0, 1, 0);
		fill_row(6, MODE_STORED, 1'b0, 2'd0, 2, 0);
		fill_row(7, MODE_STORED, 1'b0, 2'd0, 2, 2);
		// Bank starts cleared, only load rows replace it
		stored = '0;
		for (r = 0; r < ROWS; r++) begin
			if (rows[r].mode == MODE_LOAD) begin
				stored = rows[r].coeff;
			end
			for (c = 0; c < CH; c++) begin
				rows[r].exp_w[c] = correct_reading(rows[r].adc[c], stored[c]);
			end
		end
	endtask

	task automatic next_slot();
		@(posedge clk);
		#5;
	endtask

	task automatic drive_start(input mode_e m, input sample_t [CH-1:0] adc,
		input coeff_set_t [CH-1:0] cs, input sample_t [CH-1:0] exp_in);
		srdyi = 1'b1;
		mode = m;
		x_adc = adc;
		coeff = cs;
		exp_words = exp_in;
		next_slot();
		srdyi = 1'b0;
	endtask

	initial begin : driver
		int r;
		int total;
		srdyi = 1'b0;
		mode = MODE_STORED;
		x_adc = '0;
		coeff = '0;
		exp_words = '0;
		reset = 1'b1;
		build_table();
		repeat (2) @(posedge clk);
		#5;
		reset = 1'b0;
		for (r = 0; r < ROWS; r++) begin
			repeat (rows[r].gap) next_slot();
			drive_start(rows[r].mode, rows[r].adc, rows[r].coeff, rows[r].exp_w);
			if (rows[r].busy) begin
				// Mid-run strobe with other readings and a set that must not load
				repeat (8) next_slot();
				drive_start(MODE_LOAD, ~rows[r].adc, ~rows[r].coeff, rows[r].exp_w);
			end
			while (srdyo !== 1'b1) begin
				next_slot();
			end
		end
		repeat (2) next_slot();
		total = err_cnt + u_dut.u_poly_engine.u_asserts.fail_cnt;
		if (run_cnt != ROWS) begin
			$display("%0d runs were published where %0d were started", run_cnt, ROWS);
			total++;
		end
		$display("runs %0d of %0d, checker errors %0d, assertion failures %0d",
			run_cnt, ROWS, err_cnt, u_dut.u_poly_engine.u_asserts.fail_cnt);
		if (total == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// Bound worked out from the table length
	always @(posedge clk) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("timeout: the runs did not finish within %0d clock cycles", LIMIT);
			$display("CHECKS FAILED");
			$finish;
		end
	end

endmodule

// File: sources.f
nlc_num_pkg.sv
nlc_ctrl_pkg.sv
coeff_bank.sv
channel_buffer.sv
poly_engine.sv
nlc_top.sv
nlc_asserts.sv
nlc_checker.sv
tb_nlc.sv
